// File: design/proc_pkg.sv
// widths, memory sizes, opcode and select enums, instruction fields and pipeline structs
package proc_pkg;

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;
	localparam int IMEM_AW    = $clog2(IMEM_WORDS);
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	typedef logic [XLEN-1:0]       data_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// rv32 field layout, msb first
	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		logic [6:0] opcode;
	} instr_t;

	localparam instr_t EBREAK_INSTR = 32'h0010_0073;
	// addi x0,x0,0
	localparam instr_t NOP_INSTR    = 32'h0000_0013;

	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		SYSTEM = 7'b1110011
	} opcode_t;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_t;
	typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_t;
	typedef enum logic [1:0] {BR_REG, BR_MEM, BR_WB} br_fwd_t;

	typedef struct packed {
		data_t  pc;
		instr_t instr;
	} if_id_t;

	typedef struct packed {
		instr_t  instr;
		alu_op_t alu_op;
		data_t   rs1_val;
		data_t   rs2_val;
		data_t   imm;
		logic    rd_wren;
		logic    mem_rd;
		logic    mem_wr;
	} id_ex_t;

	typedef struct packed {
		instr_t instr;
		data_t  alu_res;
		data_t  st_data;
		logic   rd_wren;
		logic   mem_rd;
		logic   mem_wr;
	} ex_mem_t;

	typedef struct packed {
		instr_t instr;
		data_t  alu_res;
		data_t  ld_data;
		logic   rd_wren;
		logic   mem_rd;
	} mem_wb_t;

	// empty pipeline slots
	localparam if_id_t  IF_ID_BUBBLE  = '{pc: '0, instr: NOP_INSTR};
	localparam id_ex_t  ID_EX_BUBBLE  = '{instr: NOP_INSTR, alu_op: ALU_ADD, default: '0};
	localparam ex_mem_t EX_MEM_BUBBLE = '{instr: NOP_INSTR, default: '0};
	localparam mem_wb_t MEM_WB_BUBBLE = '{instr: NOP_INSTR, default: '0};

	typedef enum logic [2:0] {
		BRK_IDLE,
		BRK_CNT_1,
		BRK_CNT_2,
		BRK_CNT_3,
		BRK_WAIT
	} brk_state_t;

endpackage

// File: design/hazard_if.sv
// hazard control interface with stall, flush and forward selects and per-stage modports
`timescale 1ns/1ps

interface hazard_if;

	// hold pc and if/id
	logic stall_fetch;
	// taken branch, bubble into if/id
	logic flush_fetch;
	logic bubble_decode;

	// execute operand selects
	proc_pkg::fwd_sel_t fwd_a;
	proc_pkg::fwd_sel_t fwd_b;

	// branch compare operand selects
	proc_pkg::br_fwd_t br_fwd_1;
	proc_pkg::br_fwd_t br_fwd_2;

	modport ctrl (
		output stall_fetch, flush_fetch, bubble_decode,
		output fwd_a, fwd_b, br_fwd_1, br_fwd_2
	);

	modport fetch (input stall_fetch, flush_fetch);

	modport decode (input bubble_decode, br_fwd_1, br_fwd_2);

	modport execute (input fwd_a, fwd_b);

endinterface

// File: design/fetch.sv
// fetch stage with program counter, instruction memory, load port and if/id register
`timescale 1ns/1ps

module fetch (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         imem_we,
	input  logic [proc_pkg::IMEM_AW-1:0] imem_addr,
	input  proc_pkg::data_t              imem_wdata,
	input  logic                         brk_stall,
	input  proc_pkg::data_t              pc_target,
	hazard_if.fetch                      hz,
	output proc_pkg::if_id_t             if_id
);

	proc_pkg::data_t  pc;
	proc_pkg::data_t  imem [proc_pkg::IMEM_WORDS];
	proc_pkg::instr_t instr;

	// program is loaded while the core sits in reset
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
	end

	// word index from the byte pc
	assign instr = imem[pc[proc_pkg::IMEM_AW+1:2]];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (hz.flush_fetch) begin
			pc <= pc_target;
		end else if (!hz.stall_fetch && !brk_stall) begin
			pc <= pc + 32'd4;
		end
	end

	// hazard stall holds decode, breakpoint stall feeds it bubbles
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_id <= proc_pkg::IF_ID_BUBBLE;
		end else if (hz.flush_fetch) begin
			if_id <= proc_pkg::IF_ID_BUBBLE;
		end else if (!hz.stall_fetch) begin
			if (brk_stall) begin
				if_id <= proc_pkg::IF_ID_BUBBLE;
			end else begin
				if_id <= '{pc: pc, instr: instr};
			end
		end
	end

endmodule

// File: design/decode.sv
// decode stage with register file, debug read, immediates, branch resolution and id/ex register
`timescale 1ns/1ps

module decode (
	input  logic                clk,
	input  logic                rst_n,
	input  proc_pkg::if_id_t    if_id,
	hazard_if.decode            hz,
	input  logic                wb_en,
	input  proc_pkg::reg_addr_t wb_addr,
	input  proc_pkg::data_t     wb_data,
	input  proc_pkg::data_t     mem_fwd_data,
	input  proc_pkg::reg_addr_t dbg_addr,
	output proc_pkg::data_t     dbg_data,
	output proc_pkg::data_t     pc_target,
	output logic                br_taken,
	output proc_pkg::id_ex_t    id_ex
);

	proc_pkg::data_t  regs [2**proc_pkg::REG_ADDR_W];
	proc_pkg::instr_t instr;
	proc_pkg::opcode_t op;
	proc_pkg::data_t  raw;
	proc_pkg::data_t  imm_i;
	proc_pkg::data_t  imm_s;
	proc_pkg::data_t  imm_b;
	proc_pkg::data_t  rs1_val;
	proc_pkg::data_t  rs2_val;
	proc_pkg::data_t  br_op1;
	proc_pkg::data_t  br_op2;
	proc_pkg::id_ex_t dec;

	// x0 reads zero, a write in this cycle is seen by the read
	function automatic proc_pkg::data_t rf_read(
		input proc_pkg::reg_addr_t addr,
		input proc_pkg::data_t     stored,
		input logic                wen,
		input proc_pkg::reg_addr_t waddr,
		input proc_pkg::data_t     wdata
	);
		if (addr == '0) begin
			return '0;
		end
		if (wen && waddr == addr) begin
			return wdata;
		end
		return stored;
	endfunction

	function automatic proc_pkg::data_t br_pick(
		input proc_pkg::br_fwd_t sel,
		input proc_pkg::data_t   reg_val,
		input proc_pkg::data_t   mem_val,
		input proc_pkg::data_t   wb_val
	);
		case (sel)
			proc_pkg::BR_MEM: return mem_val;
			proc_pkg::BR_WB:  return wb_val;
			default:          return reg_val;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (wb_en && wb_addr != '0) begin
			regs[wb_addr] <= wb_data;
		end
	end

	assign instr = if_id.instr;
	assign raw   = if_id.instr;
	assign op    = proc_pkg::opcode_t'(instr.opcode);

	assign rs1_val  = rf_read(instr.rs1, regs[instr.rs1], wb_en, wb_addr, wb_data);
	assign rs2_val  = rf_read(instr.rs2, regs[instr.rs2], wb_en, wb_addr, wb_data);
	assign dbg_data = rf_read(dbg_addr, regs[dbg_addr], wb_en, wb_addr, wb_data);

	assign imm_i = {{20{raw[31]}}, raw[31:20]};
	assign imm_s = {{20{raw[31]}}, raw[31:25], raw[11:7]};
	assign imm_b = {{19{raw[31]}}, raw[31], raw[7], raw[30:25], raw[11:8], 1'b0};

	// beq and bne compare in decode
	assign br_op1    = br_pick(hz.br_fwd_1, rs1_val, mem_fwd_data, wb_data);
	assign br_op2    = br_pick(hz.br_fwd_2, rs2_val, mem_fwd_data, wb_data);
	assign pc_target = if_id.pc + imm_b;
	assign br_taken  = (op == proc_pkg::BRANCH) &&
		((instr.funct3 == 3'b000 && br_op1 == br_op2) ||
		 (instr.funct3 == 3'b001 && br_op1 != br_op2));

	always_comb begin
		dec         = proc_pkg::ID_EX_BUBBLE;
		dec.instr   = instr;
		dec.rs1_val = rs1_val;
		dec.rs2_val = rs2_val;
		dec.imm     = imm_i;
		case (op)
			proc_pkg::OP: begin
				dec.rd_wren = 1'b1;
				case (instr.funct3)
					3'b000:  dec.alu_op = instr.funct7[5] ? proc_pkg::ALU_SUB : proc_pkg::ALU_ADD;
					3'b100:  dec.alu_op = proc_pkg::ALU_XOR;
					3'b110:  dec.alu_op = proc_pkg::ALU_OR;
					3'b111:  dec.alu_op = proc_pkg::ALU_AND;
					default: dec.rd_wren = 1'b0;
				endcase
			end
			proc_pkg::OP_IMM: dec.rd_wren = 1'b1;
			proc_pkg::LOAD: begin
				dec.rd_wren = 1'b1;
				dec.mem_rd  = 1'b1;
			end
			proc_pkg::STORE: begin
				dec.imm    = imm_s;
				dec.mem_wr = 1'b1;
			end
			proc_pkg::BRANCH: dec.imm = imm_b;
			// ebreak and anything unsupported travel on as a nop
			default: dec.instr = proc_pkg::NOP_INSTR;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex <= proc_pkg::ID_EX_BUBBLE;
		end else if (hz.bubble_decode) begin
			id_ex <= proc_pkg::ID_EX_BUBBLE;
		end else begin
			id_ex <= dec;
		end
	end

endmodule

// File: design/execute.sv
// execute stage with operand forwarding, alu and ex/mem register
`timescale 1ns/1ps

module execute (
	input  logic              clk,
	input  logic              rst_n,
	input  proc_pkg::id_ex_t  id_ex,
	hazard_if.execute         hz,
	input  proc_pkg::data_t   mem_fwd_data,
	input  proc_pkg::data_t   wb_data,
	output proc_pkg::ex_mem_t ex_mem
);

	proc_pkg::data_t op_a;
	proc_pkg::data_t op_b;
	proc_pkg::data_t rs2_fwd;
	proc_pkg::data_t alu_res;
	logic            use_imm;

	function automatic proc_pkg::data_t fwd_pick(
		input proc_pkg::fwd_sel_t sel,
		input proc_pkg::data_t    reg_val,
		input proc_pkg::data_t    mem_val,
		input proc_pkg::data_t    wb_val
	);
		case (sel)
			proc_pkg::FWD_MEM: return mem_val;
			proc_pkg::FWD_WB:  return wb_val;
			default:           return reg_val;
		endcase
	endfunction

	assign op_a    = fwd_pick(hz.fwd_a, id_ex.rs1_val, mem_fwd_data, wb_data);
	// also the store data
	assign rs2_fwd = fwd_pick(hz.fwd_b, id_ex.rs2_val, mem_fwd_data, wb_data);

	assign use_imm = id_ex.instr.opcode inside {proc_pkg::OP_IMM, proc_pkg::LOAD, proc_pkg::STORE};
	assign op_b    = use_imm ? id_ex.imm : rs2_fwd;

	always_comb begin
		case (id_ex.alu_op)
			proc_pkg::ALU_SUB: alu_res = op_a - op_b;
			proc_pkg::ALU_AND: alu_res = op_a & op_b;
			proc_pkg::ALU_OR:  alu_res = op_a | op_b;
			proc_pkg::ALU_XOR: alu_res = op_a ^ op_b;
			default:           alu_res = op_a + op_b;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_mem <= proc_pkg::EX_MEM_BUBBLE;
		end else begin
			ex_mem <= '{
				instr:   id_ex.instr,
				alu_res: alu_res,
				st_data: rs2_fwd,
				rd_wren: id_ex.rd_wren,
				mem_rd:  id_ex.mem_rd,
				mem_wr:  id_ex.mem_wr
			};
		end
	end

endmodule

// File: design/memory.sv
// memory stage with word data memory and mem/wb register
`timescale 1ns/1ps

module memory (
	input  logic              clk,
	input  logic              rst_n,
	input  proc_pkg::ex_mem_t ex_mem,
	output proc_pkg::mem_wb_t mem_wb
);

	proc_pkg::data_t             dmem [proc_pkg::DMEM_WORDS];
	logic [proc_pkg::DMEM_AW-1:0] idx;
	proc_pkg::data_t             ld_data;

	// byte offset dropped, words only
	assign idx     = ex_mem.alu_res[proc_pkg::DMEM_AW+1:2];
	assign ld_data = dmem[idx];

	always_ff @(posedge clk) begin
		if (ex_mem.mem_wr) begin
			dmem[idx] <= ex_mem.st_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_wb <= proc_pkg::MEM_WB_BUBBLE;
		end else begin
			mem_wb <= '{
				instr:   ex_mem.instr,
				alu_res: ex_mem.alu_res,
				ld_data: ld_data,
				rd_wren: ex_mem.rd_wren,
				mem_rd:  ex_mem.mem_rd
			};
		end
	end

endmodule

// File: design/hazard_ctrl.sv
// hazard controller for forward selects, load-use and branch-use stalls and branch flush
`timescale 1ns/1ps

module hazard_ctrl (
	input  proc_pkg::if_id_t  if_id,
	input  proc_pkg::id_ex_t  id_ex,
	input  proc_pkg::ex_mem_t ex_mem,
	input  proc_pkg::mem_wb_t mem_wb,
	input  logic              br_taken,
	hazard_if.ctrl            hz
);

	proc_pkg::instr_t d;
	proc_pkg::instr_t x;
	logic             d_rs1;
	logic             d_rs2;
	logic             load_use;
	logic             branch_use;
	logic             stall;

	function automatic logic hit(
		input proc_pkg::reg_addr_t rs,
		input proc_pkg::reg_addr_t rd,
		input logic                wren
	);
		return wren && rd != '0 && rd == rs;
	endfunction

	function automatic logic uses_rs1(input logic [6:0] opcode);
		return opcode inside {proc_pkg::OP, proc_pkg::OP_IMM, proc_pkg::LOAD,
			proc_pkg::STORE, proc_pkg::BRANCH};
	endfunction

	function automatic logic uses_rs2(input logic [6:0] opcode);
		return opcode inside {proc_pkg::OP, proc_pkg::STORE, proc_pkg::BRANCH};
	endfunction

	assign d     = if_id.instr;
	assign x     = id_ex.instr;
	assign d_rs1 = uses_rs1(d.opcode);
	assign d_rs2 = uses_rs2(d.opcode);

	// load result not ready until write-back
	assign load_use = id_ex.mem_rd &&
		((d_rs1 && hit(d.rs1, x.rd, id_ex.rd_wren)) ||
		 (d_rs2 && hit(d.rs2, x.rd, id_ex.rd_wren)));

	// branch compares in decode, so execute results and loads in memory are too late
	assign branch_use = (d.opcode == proc_pkg::BRANCH) &&
		(hit(d.rs1, x.rd, id_ex.rd_wren) || hit(d.rs2, x.rd, id_ex.rd_wren) ||
		 (ex_mem.mem_rd && (hit(d.rs1, ex_mem.instr.rd, ex_mem.rd_wren) ||
		                    hit(d.rs2, ex_mem.instr.rd, ex_mem.rd_wren))));

	assign stall            = load_use || branch_use;
	assign hz.stall_fetch   = stall;
	assign hz.bubble_decode = stall;
	// stale compare while stalled
	assign hz.flush_fetch   = br_taken && !stall;

	always_comb begin
		hz.fwd_a = proc_pkg::FWD_NONE;
		if (hit(x.rs1, ex_mem.instr.rd, ex_mem.rd_wren)) begin
			hz.fwd_a = proc_pkg::FWD_MEM;
		end else if (hit(x.rs1, mem_wb.instr.rd, mem_wb.rd_wren)) begin
			hz.fwd_a = proc_pkg::FWD_WB;
		end

		hz.fwd_b = proc_pkg::FWD_NONE;
		if (hit(x.rs2, ex_mem.instr.rd, ex_mem.rd_wren)) begin
			hz.fwd_b = proc_pkg::FWD_MEM;
		end else if (hit(x.rs2, mem_wb.instr.rd, mem_wb.rd_wren)) begin
			hz.fwd_b = proc_pkg::FWD_WB;
		end
	end

	always_comb begin
		hz.br_fwd_1 = proc_pkg::BR_REG;
		if (hit(d.rs1, ex_mem.instr.rd, ex_mem.rd_wren && !ex_mem.mem_rd)) begin
			hz.br_fwd_1 = proc_pkg::BR_MEM;
		end else if (hit(d.rs1, mem_wb.instr.rd, mem_wb.rd_wren)) begin
			hz.br_fwd_1 = proc_pkg::BR_WB;
		end

		hz.br_fwd_2 = proc_pkg::BR_REG;
		if (hit(d.rs2, ex_mem.instr.rd, ex_mem.rd_wren && !ex_mem.mem_rd)) begin
			hz.br_fwd_2 = proc_pkg::BR_MEM;
		end else if (hit(d.rs2, mem_wb.instr.rd, mem_wb.rd_wren)) begin
			hz.br_fwd_2 = proc_pkg::BR_WB;
		end
	end

endmodule

// File: design/proc.sv
// processor top level with stage wiring, write-back select and breakpoint sequencer
`timescale 1ns/1ps

module proc (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         imem_we,
	input  logic [proc_pkg::IMEM_AW-1:0] imem_addr,
	input  proc_pkg::data_t              imem_wdata,
	input  logic                         ebreak_return,
	input  proc_pkg::reg_addr_t          dbg_addr,
	output proc_pkg::data_t              dbg_data,
	// pipeline drained, debugger owns the core
	output logic                         ebreak_start
);

	hazard_if hz ();

	proc_pkg::if_id_t   if_id;
	proc_pkg::id_ex_t   id_ex;
	proc_pkg::ex_mem_t  ex_mem;
	proc_pkg::mem_wb_t  mem_wb;

	proc_pkg::data_t    pc_target;
	logic               br_taken;
	proc_pkg::data_t    wb_data;
	logic               wb_en;
	proc_pkg::reg_addr_t wb_addr;

	logic               ebreak;
	logic               brk_stall;
	proc_pkg::brk_state_t brk_state;
	proc_pkg::brk_state_t brk_state_nxt;

	fetch fetch_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.brk_stall  (brk_stall),
		.pc_target  (pc_target),
		.hz         (hz),
		.if_id      (if_id)
	);

	decode decode_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.if_id        (if_id),
		.hz           (hz),
		.wb_en        (wb_en),
		.wb_addr      (wb_addr),
		.wb_data      (wb_data),
		.mem_fwd_data (ex_mem.alu_res),
		.dbg_addr     (dbg_addr),
		.dbg_data     (dbg_data),
		.pc_target    (pc_target),
		.br_taken     (br_taken),
		.id_ex        (id_ex)
	);

	execute execute_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.id_ex        (id_ex),
		.hz           (hz),
		.mem_fwd_data (ex_mem.alu_res),
		.wb_data      (wb_data),
		.ex_mem       (ex_mem)
	);

	memory memory_inst (
		.clk    (clk),
		.rst_n  (rst_n),
		.ex_mem (ex_mem),
		.mem_wb (mem_wb)
	);

	hazard_ctrl hazard_ctrl_inst (
		.if_id    (if_id),
		.id_ex    (id_ex),
		.ex_mem   (ex_mem),
		.mem_wb   (mem_wb),
		.br_taken (br_taken),
		.hz       (hz)
	);

	// write-back select
	assign wb_data = mem_wb.mem_rd ? mem_wb.ld_data : mem_wb.alu_res;
	assign wb_en   = mem_wb.rd_wren;
	assign wb_addr = mem_wb.instr.rd;

	assign ebreak       = (if_id.instr == proc_pkg::EBREAK_INSTR);
	assign ebreak_start = (brk_state == proc_pkg::BRK_WAIT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			brk_state <= proc_pkg::BRK_IDLE;
		end else begin
			brk_state <= brk_state_nxt;
		end
	end

	// three counts let the older instructions write back,
	// fetch stays frozen until the debugger lets go
	always_comb begin
		brk_state_nxt = brk_state;
		brk_stall     = 1'b1;
		case (brk_state)
			proc_pkg::BRK_IDLE: begin
				brk_stall = ebreak;
				if (ebreak) begin
					brk_state_nxt = proc_pkg::BRK_CNT_1;
				end
			end
			proc_pkg::BRK_CNT_1: brk_state_nxt = proc_pkg::BRK_CNT_2;
			proc_pkg::BRK_CNT_2: brk_state_nxt = proc_pkg::BRK_CNT_3;
			proc_pkg::BRK_CNT_3: brk_state_nxt = proc_pkg::BRK_WAIT;
			proc_pkg::BRK_WAIT: begin
				if (ebreak_return) begin
					brk_state_nxt = proc_pkg::BRK_IDLE;
					brk_stall     = 1'b0;
				end
			end
			default: begin
				brk_state_nxt = proc_pkg::BRK_IDLE;
				brk_stall     = 1'b0;
			end
		endcase
	end

endmodule

// File: verification/proc_assertions.sv
// bound checks on the breakpoint handshake, the drained core and the debug read port
`timescale 1ns/1ps

module proc_assertions (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 ebreak_return,
	input logic                 ebreak_start,
	input logic                 brk_stall,
	input proc_pkg::brk_state_t brk_state,
	input proc_pkg::reg_addr_t  dbg_addr,
	input proc_pkg::data_t      dbg_data
);

	// read by the testbench
	int fail_count = 0;

	a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !ebreak_start)
		else begin
			$error("ebreak_start high during reset");
			fail_count++;
		end

	// ebreak in decode, four edges until the debugger owns the core
	a_start_latency: assert property (@(posedge clk) disable iff (!rst_n)
		brk_state == proc_pkg::BRK_IDLE && brk_stall |-> ##4 ebreak_start)
		else begin
			$error("ebreak_start late after ebreak in decode");
			fail_count++;
		end

	a_start_holds: assert property (@(posedge clk) disable iff (!rst_n)
		ebreak_start && !ebreak_return |=> ebreak_start)
		else begin
			$error("ebreak_start dropped without ebreak_return");
			fail_count++;
		end

	a_start_falls: assert property (@(posedge clk) disable iff (!rst_n)
		ebreak_start && ebreak_return |=> !ebreak_start)
		else begin
			$error("ebreak_start still high after ebreak_return");
			fail_count++;
		end

	// frozen fetch and drained pipe, so nothing writes back while waiting
	a_regs_frozen: assert property (@(posedge clk) disable iff (!rst_n)
		ebreak_start && $past(ebreak_start && !ebreak_return) && $stable(dbg_addr)
		|-> dbg_data === $past(dbg_data))
		else begin
			$error("register file changed while waiting for the debugger");
			fail_count++;
		end

	a_x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
		dbg_addr == '0 |-> dbg_data == '0)
		else begin
			$error("debug read of x0 not zero");
			fail_count++;
		end

endmodule

bind proc proc_assertions brk_checks (
	.clk           (clk),
	.rst_n         (rst_n),
	.ebreak_return (ebreak_return),
	.ebreak_start  (ebreak_start),
	.brk_stall     (brk_stall),
	.brk_state     (brk_state),
	.dbg_addr      (dbg_addr),
	.dbg_data      (dbg_data)
);

// File: verification/proc_tb.sv
// testbench for proc with program generation, reference model, debug checks and watchdog
`timescale 1ns/1ps

module proc_tb;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 16;

	logic                         clk;
	logic                         rst_n;
	logic                         imem_we;
	logic [proc_pkg::IMEM_AW-1:0] imem_addr;
	proc_pkg::data_t              imem_wdata;
	logic                         ebreak_return;
	proc_pkg::reg_addr_t          dbg_addr;
	proc_pkg::data_t              dbg_data;
	logic                         ebreak_start;

	// program image and architectural model state
	proc_pkg::data_t prog  [proc_pkg::IMEM_WORDS];
	proc_pkg::data_t mregs [32];
	proc_pkg::data_t mdmem [proc_pkg::DMEM_WORDS];
	logic [31:0]     mvalid;
	proc_pkg::data_t mpc;
	int              n_instr;
	int              n_seg;
	logic            prog_ready;

	proc dut0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.imem_we       (imem_we),
		.imem_addr     (imem_addr),
		.imem_wdata    (imem_wdata),
		.ebreak_return (ebreak_return),
		.dbg_addr      (dbg_addr),
		.dbg_data      (dbg_data),
		.ebreak_start  (ebreak_start)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic proc_pkg::data_t alu_reg(int funct7, int funct3, int rd, int rs1,
		int rs2);
		return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic proc_pkg::data_t addi(int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
	endfunction

	function automatic proc_pkg::data_t lw(int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
	endfunction

	function automatic proc_pkg::data_t sw(int rs2, int rs1, int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	// funct3 0 is beq, 1 is bne
	function automatic proc_pkg::data_t branch(int funct3, int rs1, int rs2, int offset);
		return {offset[12], offset[10:5], rs2[4:0], rs1[4:0], funct3[2:0],
			offset[4:1], offset[11], 7'b1100011};
	endfunction

	task automatic emit(input proc_pkg::data_t word);
		prog[n_instr] = word;
		n_instr++;
		if (word == proc_pkg::EBREAK_INSTR) begin
			n_seg++;
		end
	endtask

	task automatic build_program();
		int k1;
		int k2;
		int k3;
		int k4;
		int v;
		int base;
		k1   = $urandom;
		k2   = $urandom;
		k3   = $urandom;
		k4   = $urandom;
		v    = ($urandom & 32'h3ff) | 32'd1;
		base = ($urandom % 16) * 4;
		n_instr = 0;
		n_seg   = 0;
		// dependent alu chain, x0 writes at the end
		emit(addi(1, 0, k1));
		emit(addi(2, 0, k2));
		emit(alu_reg(0, 0, 3, 1, 2));
		emit(alu_reg(32, 0, 4, 3, 1));
		emit(alu_reg(0, 7, 5, 4, 3));
		emit(alu_reg(0, 6, 6, 5, 2));
		emit(alu_reg(0, 4, 7, 6, 4));
		emit(addi(8, 7, k3));
		emit(addi(0, 1, 5));
		emit(alu_reg(0, 0, 0, 1, 2));
		emit(proc_pkg::EBREAK_INSTR);
		// store, load, load-use and a store waiting on a load
		emit(addi(9, 0, base));
		emit(sw(7, 9, 4));
		emit(lw(10, 9, 4));
		emit(alu_reg(0, 0, 11, 10, 1));
		emit(lw(12, 9, 4));
		emit(sw(12, 9, 8));
		emit(lw(13, 9, 8));
		emit(proc_pkg::EBREAK_INSTR);
		// branches, x16 and x20 must survive the wrong path
		emit(addi(16, 0, 77));
		emit(addi(20, 0, 88));
		emit(addi(14, 0, v));
		emit(addi(15, 0, v));
		emit(branch(0, 14, 15, 8));
		emit(addi(16, 0, 111));
		emit(addi(17, 0, 222));
		emit(branch(1, 14, 15, 8));
		emit(addi(18, 0, 333));
		emit(branch(1, 14, 0, 8));
		emit(addi(16, 0, 555));
		emit(lw(19, 9, 4));
		emit(branch(0, 19, 7, 8));
		emit(addi(20, 0, 444));
		emit(addi(0, 14, 1));
		emit(proc_pkg::EBREAK_INSTR);
		// runs after a resume, branch direction depends on the data
		emit(addi(21, 1, k4));
		emit(alu_reg(0, 0, 22, 21, 11));
		emit(branch(0, 21, 22, 8));
		emit(addi(23, 22, 7));
		emit(alu_reg(0, 4, 24, 22, 19));
		emit(proc_pkg::EBREAK_INSTR);
		// rest of imem holds nops that carry their own address
		for (int i = n_instr; i < proc_pkg::IMEM_WORDS; i++) begin
			prog[i] = addi(0, 0, i);
		end
	endtask

	// runs the program from mpc up to the next ebreak
	task automatic model_segment();
		proc_pkg::data_t ins;
		proc_pkg::data_t a;
		proc_pkg::data_t b;
		proc_pkg::data_t imm_i;
		proc_pkg::data_t imm_s;
		proc_pkg::data_t imm_b;
		proc_pkg::data_t res;
		proc_pkg::data_t next_pc;
		logic            wr;
		ins = prog[mpc[7:2]];
		while (ins != proc_pkg::EBREAK_INSTR) begin
			a       = mregs[ins[19:15]];
			b       = mregs[ins[24:20]];
			imm_i   = {{20{ins[31]}}, ins[31:20]};
			imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			next_pc = mpc + 32'd4;
			wr      = 1'b0;
			res     = '0;
			case (ins[6:0])
				7'b0110011: begin
					wr = 1'b1;
					case (ins[14:12])
						3'd0:    res = ins[30] ? a - b : a + b;
						3'd4:    res = a ^ b;
						3'd6:    res = a | b;
						default: res = a & b;
					endcase
				end
				7'b0010011: begin
					wr  = 1'b1;
					res = a + imm_i;
				end
				7'b0000011: begin
					wr  = 1'b1;
					res = a + imm_i;
					res = mdmem[res[7:2]];
				end
				7'b0100011: begin
					res = a + imm_s;
					mdmem[res[7:2]] = b;
				end
				7'b1100011: begin
					if (ins[12] ? (a != b) : (a == b)) begin
						next_pc = mpc + imm_b;
					end
				end
				default: begin
				end
			endcase
			if (wr && ins[11:7] != 5'd0) begin
				mregs[ins[11:7]]  = res;
				mvalid[ins[11:7]] = 1'b1;
			end
			mpc = next_pc;
			ins = prog[mpc[7:2]];
		end
		// step over the ebreak
		mpc = mpc + 32'd4;
	endtask

	task automatic wait_breakpoint();
		do begin
			@(negedge clk);
		end while (ebreak_start !== 1'b1);
	endtask

	// unwritten registers are skipped, x0 is always compared
	task automatic check_registers(input int seg);
		for (int r = 0; r < 32; r++) begin
			@(posedge clk);
			#1;
			dbg_addr = proc_pkg::reg_addr_t'(r);
			@(negedge clk);
			assert (!mvalid[r] || dbg_data === mregs[r]) else begin
				$display("ERROR %0t dbg_data x%0d expected %08h actual %08h",
					$time, r, mregs[r], dbg_data);
				$display("tests failed");
				$fatal(1, "register file mismatch at breakpoint %0d", seg);
			end
		end
	endtask

	task automatic resume_core();
		@(posedge clk);
		#1;
		ebreak_return = 1'b1;
		@(posedge clk);
		#1;
		ebreak_return = 1'b0;
	endtask

	// bound assertion failures end the run here
	always @(negedge clk) begin
		if (dut0.brk_checks.fail_count != 0) begin
			$display("tests failed");
			$fatal(1, "bound assertion failed");
		end
	end

	initial begin
		longint limit_ns;
		wait (prog_ready === 1'b1);
		limit_ns = longint'(n_instr * 40 + proc_pkg::IMEM_WORDS + RESET_CYCLES + n_seg * 80);
		limit_ns = limit_ns * CLK_PERIOD;
		#(limit_ns);
		$display("watchdog expired, the core never reached its next breakpoint");
		$display("tests failed");
		$fatal(1, "timeout");
	end

	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		imem_we       = 1'b0;
		imem_addr     = '0;
		imem_wdata    = '0;
		ebreak_return = 1'b0;
		dbg_addr      = '0;
		prog_ready    = 1'b0;
		void'($urandom(32'he623));
		build_program();
		for (int i = 0; i < 32; i++) begin
			mregs[i] = '0;
		end
		mvalid     = 32'h1;
		mpc        = '0;
		prog_ready = 1'b1;
		// program load, then the reset hold
		for (int i = 0; i < proc_pkg::IMEM_WORDS; i++) begin
			@(posedge clk);
			#1;
			imem_we    = 1'b1;
			imem_addr  = i[proc_pkg::IMEM_AW-1:0];
			imem_wdata = prog[i];
		end
		@(posedge clk);
		#1;
		imem_we = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int s = 0; s < n_seg; s++) begin
			model_segment();
			wait_breakpoint();
			check_registers(s);
			resume_core();
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		if (dut0.brk_checks.fail_count == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("tests failed");
			$fatal(1, "bound assertion failed");
		end
	end

endmodule

// File: compile.f
design/proc_pkg.sv
design/hazard_if.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/memory.sv
design/hazard_ctrl.sv
design/proc.sv
verification/proc_assertions.sv
verification/proc_tb.sv

// File: Makefile
# Verilator build and run for the pipelined core testbench

VERILATOR ?= verilator
TOP       ?= proc_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(wildcard design/*.sv verification/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
